// ==== build.f ====
common/zports_pkg.sv
hw/port_decode.sv
hw/port_read.sv
hw/sys_ctl.sv
hw/paging/page_ctl.sv
hw/zports_top.sv
testbench/zports_props.sv
testbench/tb_zports.sv

// ==== testbench/tb_zports.sv ====
// I/O port block testbench: seeded random port cycles checked against a reference model
module tb_zports
	import zports_pkg::*;
();

	localparam int CLK_PERIOD    = 4;
	localparam int RESET_CYCLES  = 16;
	localparam int PORT_CYCLES   = 2000;
	localparam int MARGIN        = 200;	// directed reads, second reset, slack
	localparam int WATCHDOG_TIME = (2 * RESET_CYCLES + 2 * PORT_CYCLES + MARGIN) * CLK_PERIOD;

	logic        clk;
	logic        rst;
	logic [7:0]  din;
	zaddr_u      a;
	logic        iord;
	logic        iowr_s;
	logic        iord_s;
	logic        wr;
	logic        opfetch;
	logic        dos;
	logic [4:0]  keys_in;
	logic        tape_read;
	logic [4:0]  kj_in;
	logic [7:0]  mus_in;
	logic [7:0]  sd_dataout;

	logic [7:0]  dout;
	logic        dataout;
	logic        porthit;
	logic        external_port;
	logic        zborder_wr;
	logic        beeper_wr;
	logic        covox_wr;
	logic        zvpage_wr;
	logic        border_wr;
	logic        vpage_wr;
	logic        vconf_wr;
	logic        tsconf_wr;
	logic        palsel_wr;
	logic [31:0] xt_page;
	logic [4:0]  fmaddr;
	logic [7:0]  sysconf;
	logic [7:0]  memconf;
	logic [7:0]  im2vect;
	logic        sdcs_n;
	logic        sd_start;
	logic [7:0]  sd_datain;

	// reference model state
	logic [7:0]  m_sysconf;
	logic [7:0]  m_memconf;
	logic [7:0]  m_im2vect;
	logic [4:0]  m_fmaddr;
	logic [7:0]  m_page [0:3];
	logic        m_lck48;
	logic        m_m1lock;	// lock128 flag from last opcode fetch
	logic        m_sdcs_n;
	logic        m_pwr_up;

	int unsigned err_count;
	int unsigned check_count;

	zports_top dut_i (.*);

	initial
	begin
		clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
		check_count++;
		assert (got === exp)
		else
		begin
			err_count++;
			$display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	function automatic logic [7:0] pick_index();
		case ($urandom_range(0, 12))
			0: return XR_VCONF;
			1: return XR_VPAGE;
			2: return XR_TSCONF;
			3: return XR_PALSEL;
			4: return XR_XBORDER;
			5: return XR_RAMPAGE;
			6: return XR_RAMPAGE + 8'd1;
			7: return XR_RAMPAGE + 8'd2;
			8: return XR_RAMPAGE + 8'd3;
			9: return XR_FMADDR;
			10: return XR_SYSCONF;
			11: return XR_MEMCONF;
			default: return XR_IM2VECT;
		endcase
	endfunction

	// mostly the ports the block knows, now and then any byte
	function automatic logic [15:0] rand_addr();
		logic [7:0] port;
		logic [7:0] xr;
		case ($urandom_range(0, 9))
			0: port = PORT_FE;
			1, 2: port = PORT_XT;
			3: port = PORT_FD;
			4: port = PORT_COVOX;
			5: port = PORT_KJOY;
			6: port = PORT_KMOUSE;
			7: port = PORT_SDCFG;
			8: port = PORT_SDDAT;
			default: port = 8'($urandom);
		endcase
		xr = 8'($urandom);
		if (port == PORT_XT && $urandom_range(0, 3) != 0)
			xr = pick_index();
		return {xr, port};
	endfunction

	// compare outputs with the model, then step the model over the coming edge
	task automatic check_cycle();
		logic [7:0] port;
		logic [7:0] xr;
		logic       hit_any;
		logic       hit_xt;
		logic       hit_sdd;
		logic       ext;
		logic       xt_wr;
		logic       fd_wr;
		logic       lock;
		logic [7:0] exp_dout;
		port    = a.raw[7:0];
		xr      = a.raw[15:8];
		hit_xt  = (port == PORT_XT);
		hit_sdd = (port == PORT_SDDAT) && !dos;
		hit_any = (port == PORT_FE) || hit_xt || (port == PORT_FD) || (port == PORT_COVOX)
			|| (port == PORT_KMOUSE)
			|| (!dos && (port == PORT_KJOY || port == PORT_SDCFG || port == PORT_SDDAT));
		ext     = (port == PORT_FD) && a.raw[15];
		xt_wr   = hit_xt && iowr_s;
		fd_wr   = (port == PORT_FD) && !a.raw[15] && iowr_s && !m_lck48;

		exp_dout = 8'hFF;
		if (port == PORT_FE)
			exp_dout = {1'b1, tape_read, 1'b0, keys_in};
		else if (hit_xt)
		begin
			if (xr == 8'h00)
				exp_dout = {1'b0, m_pwr_up, 6'b000000};
			else if (xr == 8'h12 || xr == 8'h13)
				exp_dout = m_page[xr[1:0]];
		end
		else if (port == PORT_KJOY && !dos)
			exp_dout = {3'b000, kj_in};
		else if (port == PORT_KMOUSE)
			exp_dout = mus_in;
		else if (port == PORT_SDCFG && !dos)
			exp_dout = 8'h00;
		else if (hit_sdd)
			exp_dout = sd_dataout;

		check_value("porthit", porthit, hit_any);
		check_value("external_port", external_port, ext);
		check_value("dataout", dataout, hit_any && iord && !ext);
		check_value("dout", dout, exp_dout);
		check_value("zborder_wr", zborder_wr, (port == PORT_FE) && iowr_s);
		check_value("beeper_wr", beeper_wr, (port == PORT_FE) && iowr_s);
		check_value("covox_wr", covox_wr, (port == PORT_COVOX) && iowr_s);
		check_value("zvpage_wr", zvpage_wr, fd_wr);
		check_value("vconf_wr", vconf_wr, xt_wr && xr == XR_VCONF);
		check_value("vpage_wr", vpage_wr, xt_wr && xr == XR_VPAGE);
		check_value("tsconf_wr", tsconf_wr, xt_wr && xr == XR_TSCONF);
		check_value("palsel_wr", palsel_wr, xt_wr && xr == XR_PALSEL);
		check_value("border_wr", border_wr, xt_wr && xr == XR_XBORDER);
		check_value("sd_start", sd_start, hit_sdd && (iowr_s || iord_s));
		check_value("sd_datain", sd_datain, wr ? din : 8'hFF);
		check_value("sysconf", sysconf, m_sysconf);
		check_value("memconf", memconf, m_memconf);
		check_value("im2vect", im2vect, m_im2vect);
		check_value("fmaddr", fmaddr, m_fmaddr);
		check_value("xt_page", xt_page, {m_page[3], m_page[2], m_page[1], m_page[0]});
		check_value("sdcs_n", sdcs_n, m_sdcs_n);

		lock = m_memconf[7] ? m_m1lock : m_memconf[6];	// old values, before this edge
		if (fd_wr)
		begin
			m_memconf[0] = din[4];
			m_page[3]    = {3'b000, lock ? 2'b00 : din[7:6], din[2:0]};
			m_lck48      = din[5];
		end
		else if (xt_wr)
		begin
			if (xr >= 8'h10 && xr <= 8'h13)
				m_page[xr[1:0]] = din;
			if (xr == XR_MEMCONF)
				m_memconf = din;
			if (xr == XR_SYSCONF)
				m_sysconf = din;
			if (xr == XR_IM2VECT)
				m_im2vect = din;
			if (xr == XR_FMADDR)
				m_fmaddr = din[4:0];
		end
		if ((port == PORT_SDCFG) && !dos && iowr_s)
			m_sdcs_n = din[1];
		if (hit_xt && xr == 8'h00 && iord_s)
			m_pwr_up = 1'b0;
		if (opfetch)
			m_m1lock = (din[7] == din[6]);
	endtask

	// kind 0 idle, 1 write, 2 read
	task automatic port_cycle(input logic [15:0] addr, input logic [7:0] data, input int kind);
		@(posedge clk);
		#1;
		a          = addr;
		din        = data;
		iowr_s     = (kind == 1);
		iord_s     = (kind == 2);
		iord       = (kind == 2) ? 1'b1 : 1'($urandom_range(0, 1));
		wr         = (kind == 1) ? 1'b1 : ((kind == 2) ? 1'b0 : 1'($urandom_range(0, 1)));
		dos        = ($urandom_range(0, 3) == 0);
		opfetch    = ($urandom_range(0, 7) == 0);
		keys_in    = 5'($urandom);
		tape_read  = 1'($urandom);
		kj_in      = 5'($urandom);
		mus_in     = 8'($urandom);
		sd_dataout = 8'($urandom);
		#2;
		check_cycle();
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#1;
		rst     = 1'b1;
		iowr_s  = 1'b0;
		iord_s  = 1'b0;
		opfetch = 1'b0;
		repeat (RESET_CYCLES)
			@(posedge clk);
		#1;
		rst       = 1'b0;
		m_sysconf = SYSCONF_RST;
		m_memconf = MEMCONF_RST;
		m_im2vect = IM2VECT_RST;
		m_fmaddr  = 5'd0;
		m_page[0] = RAMPAGE_RST0;
		m_page[1] = RAMPAGE_RST1;
		m_page[2] = RAMPAGE_RST2;
		m_page[3] = RAMPAGE_RST3;
		m_lck48   = 1'b0;
		m_m1lock  = 1'b0;
		m_sdcs_n  = 1'b1;
		m_pwr_up  = 1'b1;
		#2;
		check_value("sysconf after reset", sysconf, 8'h01);
		check_value("memconf after reset", memconf, 8'h04);
		check_value("im2vect after reset", im2vect, 8'hFF);
		check_value("fmaddr after reset", fmaddr, 5'd0);
		check_value("xt_page after reset", xt_page, 32'h0002_0500);
		check_value("sdcs_n after reset", sdcs_n, 1'b1);
		// power-up bit reads 1 once, then 0
		port_cycle(16'h00AF, 8'h00, 2);
		check_value("first status read", dout, 8'h40);
		port_cycle(16'h00AF, 8'h00, 2);
		check_value("second status read", dout, 8'h00);
	endtask

	initial
	begin
		#(WATCHDOG_TIME);
		$display("watchdog expired before the random port cycles were done");
		$display("Test FAILED");
		$finish;
	end

	initial
	begin
		logic [15:0] addr;
		logic [7:0]  data;
		int          kind;
		rst         = 1'b1;
		a           = '0;
		din         = 8'h00;
		iord        = 1'b0;
		iowr_s      = 1'b0;
		iord_s      = 1'b0;
		wr          = 1'b0;
		opfetch     = 1'b0;
		dos         = 1'b0;
		keys_in     = 5'h1F;
		tape_read   = 1'b0;
		kj_in       = 5'h00;
		mus_in      = 8'hFF;
		sd_dataout  = 8'hFF;
		err_count   = 0;
		check_count = 0;
		void'($urandom(32'h1266));

		apply_reset();
		for (int i = 0; i < PORT_CYCLES; i++)
		begin
			if (i == PORT_CYCLES / 2)
				apply_reset();	// clears lck48 for a second round
			addr = rand_addr();
			data = 8'($urandom);
			kind = $urandom_range(0, 2);
			if (addr[7:0] == PORT_FD && $urandom_range(0, 15) != 0)
				data[5] = 1'b0;	// keep paging unlocked most of the time
			port_cycle(addr, data, kind);
			port_cycle(rand_addr(), 8'($urandom), 0);
		end

		$display("checks %0d, errors %0d, property errors %0d",
			check_count, err_count, dut_i.props_i.prop_errors);
		if (err_count == 0 && dut_i.props_i.prop_errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// ==== testbench/zports_props.sv ====
// concurrent checks on the I/O port block strobes and sd card control
module zports_props
(
	input logic clk,
	input logic rst,
	input logic iowr_s,
	input logic dos,
	input logic zvpage_wr,
	input logic vconf_wr,
	input logic vpage_wr,
	input logic tsconf_wr,
	input logic palsel_wr,
	input logic border_wr,
	input logic sd_start,
	input logic sdcs_n
);

	int unsigned prop_errors = 0;	// read by the testbench top

	video_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0({vconf_wr, vpage_wr, tsconf_wr, palsel_wr, border_wr, zvpage_wr}))
	else
	begin
		prop_errors++;
		$error("more than one video strobe active in one cycle");
	end

	zvpage_needs_write: assert property (@(posedge clk) disable iff (rst) zvpage_wr |-> iowr_s)
	else
	begin
		prop_errors++;
		$error("zvpage_wr active without an I/O write strobe");
	end

	sd_start_no_dos: assert property (@(posedge clk) disable iff (rst) sd_start |-> !dos)
	else
	begin
		prop_errors++;
		$error("sd_start active while dos is high");
	end

	// card stays deselected right after reset
	sdcs_after_reset: assert property (@(posedge clk) $fell(rst) |-> sdcs_n)
	else
	begin
		prop_errors++;
		$error("sdcs_n low in the cycle after reset");
	end

endmodule

bind zports_top zports_props props_i
(
	.clk       (clk),
	.rst       (rst),
	.iowr_s    (iowr_s),
	.dos       (dos),
	.zvpage_wr (zvpage_wr),
	.vconf_wr  (vconf_wr),
	.vpage_wr  (vpage_wr),
	.tsconf_wr (tsconf_wr),
	.palsel_wr (palsel_wr),
	.border_wr (border_wr),
	.sd_start  (sd_start),
	.sdcs_n    (sdcs_n)
);

// ==== hw/zports_top.sv ====
// Z80 I/O port block top: address decode, read data, system registers and memory paging
module zports_top
	import zports_pkg::*;
(
	input  logic        clk,
	input  logic        rst,

	input  logic [7:0]  din,
	input  zaddr_u      a,
	input  logic        iord,	// level, for data enable
	input  logic        iowr_s,
	input  logic        iord_s,
	input  logic        wr,
	input  logic        opfetch,
	input  logic        dos,

	input  logic [4:0]  keys_in,
	input  logic        tape_read,
	input  logic [4:0]  kj_in,
	input  logic [7:0]  mus_in,
	input  logic [7:0]  sd_dataout,

	output logic [7:0]  dout,
	output logic        dataout,
	output logic        porthit,
	output logic        external_port,

	output logic        zborder_wr,
	output logic        beeper_wr,
	output logic        covox_wr,
	output logic        zvpage_wr,
	output logic        border_wr,
	output logic        vpage_wr,
	output logic        vconf_wr,
	output logic        tsconf_wr,
	output logic        palsel_wr,

	output logic [31:0] xt_page,
	output logic [4:0]  fmaddr,
	output logic [7:0]  sysconf,
	output logic [7:0]  memconf,
	output logic [7:0]  im2vect,

	output logic        sdcs_n,
	output logic        sd_start,
	output logic [7:0]  sd_datain
);

	logic [PSEL_W-1:0] port_sel;
	logic              xt_wr;
	logic              fe_wr;
	logic              fd_wr;
	logic              sd_cfg_wr;
	logic              sd_dat_wr;
	logic              sd_dat_rd;
	logic              xstat_rd;
	logic              pwr_up;

	// #FE write drives both border colour and beeper
	assign zborder_wr = fe_wr;
	assign beeper_wr  = fe_wr;

	port_decode decode_i
	(
		.a             (a),
		.iord          (iord),
		.iowr_s        (iowr_s),
		.iord_s        (iord_s),
		.dos           (dos),
		.port_sel      (port_sel),
		.porthit       (porthit),
		.external_port (external_port),
		.dataout       (dataout),
		.xt_wr         (xt_wr),
		.fe_wr         (fe_wr),
		.fd_wr         (fd_wr),
		.covox_wr      (covox_wr),
		.sd_cfg_wr     (sd_cfg_wr),
		.sd_dat_wr     (sd_dat_wr),
		.sd_dat_rd     (sd_dat_rd),
		.xstat_rd      (xstat_rd)
	);

	sys_ctl sys_i
	(
		.clk       (clk),
		.rst       (rst),
		.xt_wr     (xt_wr),
		.xreg      (a.f.xreg),
		.din       (din),
		.wr        (wr),
		.sd_cfg_wr (sd_cfg_wr),
		.sd_dat_wr (sd_dat_wr),
		.sd_dat_rd (sd_dat_rd),
		.xstat_rd  (xstat_rd),
		.sysconf   (sysconf),
		.im2vect   (im2vect),
		.fmaddr    (fmaddr),
		.sdcs_n    (sdcs_n),
		.pwr_up    (pwr_up),
		.vconf_wr  (vconf_wr),
		.vpage_wr  (vpage_wr),
		.tsconf_wr (tsconf_wr),
		.palsel_wr (palsel_wr),
		.border_wr (border_wr),
		.sd_start  (sd_start),
		.sd_datain (sd_datain)
	);

	page_ctl page_i
	(
		.clk       (clk),
		.rst       (rst),
		.a         (a),
		.din       (din),
		.opfetch   (opfetch),
		.xt_wr     (xt_wr),
		.fd_wr     (fd_wr),
		.xt_page   (xt_page),
		.memconf   (memconf),
		.zvpage_wr (zvpage_wr)
	);

	port_read read_i
	(
		.port_sel   (port_sel),
		.xreg       (a.f.xreg),
		.pwr_up     (pwr_up),
		.xt_page    (xt_page),
		.keys_in    (keys_in),
		.tape_read  (tape_read),
		.kj_in      (kj_in),
		.mus_in     (mus_in),
		.sd_dataout (sd_dataout),
		.dout       (dout)
	);

endmodule

// ==== hw/paging/page_ctl.sv ====
// memory paging: rampage and memconf registers, #7FFD port with lock48 and lock128
module page_ctl
	import zports_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  zaddr_u      a,
	input  logic [7:0]  din,
	input  logic        opfetch,
	input  logic        xt_wr,
	input  logic        fd_wr,

	output logic [31:0] xt_page,
	output logic [7:0]  memconf,
	output logic        zvpage_wr
);

	logic [7:0] rampage [0:3];
	logic       lck48;		// set by #7FFD bit 5, until reset
	logic       m1_lock128;	// from last fetched opcode
	logic       lock128;
	logic       rampage_hit;

	assign xt_page = {rampage[3], rampage[2], rampage[1], rampage[0]};

	// memconf bit 7 picks the lock source, bit 6 is the static lock
	assign lock128 = memconf[7] ? m1_lock128 : memconf[6];

	assign zvpage_wr   = fd_wr && !lck48;
	assign rampage_hit = (a.f.xreg[7:2] == XR_RAMPAGE[7:2]);

	always_ff @(posedge clk)
	begin
		if (rst)
			m1_lock128 <= 1'b0;
		else if (opfetch)
			m1_lock128 <= (din[7] == din[6]);
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			memconf    <= MEMCONF_RST;
			rampage[0] <= RAMPAGE_RST0;
			rampage[1] <= RAMPAGE_RST1;
			rampage[2] <= RAMPAGE_RST2;
			rampage[3] <= RAMPAGE_RST3;
			lck48      <= 1'b0;
		end
		else if (zvpage_wr)
		begin
			memconf[0] <= din[4];	// rom select
			// bits 7:6 extend the page to 512K unless locked
			rampage[3] <= {3'b000, lock128 ? 2'b00 : din[7:6], din[2:0]};
			lck48      <= din[5];
		end
		else if (xt_wr)
		begin
			if (rampage_hit)
				rampage[a.f.xreg[1:0]] <= din;
			if (a.f.xreg == XR_MEMCONF)
				memconf <= din;
		end
	end

endmodule

// ==== hw/sys_ctl.sv ====
// #nnAF system registers, video register strobes, sd card control and power-up flag
module sys_ctl
	import zports_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       xt_wr,
	input  logic [7:0] xreg,
	input  logic [7:0] din,
	input  logic       wr,
	input  logic       sd_cfg_wr,
	input  logic       sd_dat_wr,
	input  logic       sd_dat_rd,
	input  logic       xstat_rd,

	output logic [7:0] sysconf,
	output logic [7:0] im2vect,
	output logic [4:0] fmaddr,
	output logic       sdcs_n,
	output logic       pwr_up,
	output logic       vconf_wr,
	output logic       vpage_wr,
	output logic       tsconf_wr,
	output logic       palsel_wr,
	output logic       border_wr,
	output logic       sd_start,
	output logic [7:0] sd_datain
);

	// video registers themselves sit in the video block
	assign vconf_wr  = xt_wr && (xreg == XR_VCONF);
	assign vpage_wr  = xt_wr && (xreg == XR_VPAGE);
	assign tsconf_wr = xt_wr && (xreg == XR_TSCONF);
	assign palsel_wr = xt_wr && (xreg == XR_PALSEL);
	assign border_wr = xt_wr && (xreg == XR_XBORDER);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			sysconf <= SYSCONF_RST;
			im2vect <= IM2VECT_RST;
			fmaddr  <= 5'd0;	// palette map window closed
		end
		else if (xt_wr)
		begin
			case (xreg)
				XR_SYSCONF:
					sysconf <= din;
				XR_IM2VECT:
					im2vect <= din;
				XR_FMADDR:
					fmaddr <= din[4:0];
				default:
					;
			endcase
		end
	end

	// card deselected until software says otherwise
	always_ff @(posedge clk)
	begin
		if (rst)
			sdcs_n <= 1'b1;
		else if (sd_cfg_wr)
			sdcs_n <= din[1];
	end

	// a data read also clocks one spi byte, shifting out #FF
	assign sd_start  = sd_dat_wr || sd_dat_rd;
	assign sd_datain = wr ? din : 8'hFF;

	// first status read still sees 1, cleared behind it
	always_ff @(posedge clk)
	begin
		if (rst)
			pwr_up <= 1'b1;
		else if (xstat_rd)
			pwr_up <= 1'b0;
	end

endmodule

// ==== hw/port_read.sv ====
// read data multiplexer for the internal ports
module port_read
	import zports_pkg::*;
(
	input  logic [PSEL_W-1:0] port_sel,
	input  logic [7:0]        xreg,
	input  logic              pwr_up,
	input  logic [31:0]       xt_page,
	input  logic [4:0]        keys_in,
	input  logic              tape_read,
	input  logic [4:0]        kj_in,
	input  logic [7:0]        mus_in,
	input  logic [7:0]        sd_dataout,

	output logic [7:0]        dout
);

	logic [7:0] xt_dout;
	logic [7:0] page_byte;

	assign page_byte = xt_page[xreg[1:0]*8 +: 8];

	// only status and the upper two page registers read back
	always_comb
	begin
		if (xreg == XR_XSTAT)
			xt_dout = {1'b0, pwr_up, 6'b000000};
		else if (xreg == (XR_RAMPAGE + 8'd2) || xreg == (XR_RAMPAGE + 8'd3))
			xt_dout = page_byte;
		else
			xt_dout = 8'hFF;
	end

	always_comb
	begin
		case (port_sel)
			PSEL_FE:
				dout = {1'b1, tape_read, 1'b0, keys_in};
			PSEL_XT:
				dout = xt_dout;
			PSEL_KJOY:
				dout = {3'b000, kj_in};
			PSEL_KMOUSE:
				dout = mus_in;
			PSEL_SDCFG:
				dout = 8'h00;	// card present, not write protected
			PSEL_SDDAT:
				dout = sd_dataout;
			default:
				dout = 8'hFF;	// idle bus
		endcase
	end

endmodule

// ==== hw/port_decode.sv ====
// I/O address decoder: port select, bus hit, read enable and per-port strobes
module port_decode
	import zports_pkg::*;
(
	input  zaddr_u            a,
	input  logic              iord,
	input  logic              iowr_s,
	input  logic              iord_s,
	input  logic              dos,

	output logic [PSEL_W-1:0] port_sel,
	output logic              porthit,
	output logic              external_port,
	output logic              dataout,
	output logic              xt_wr,
	output logic              fe_wr,
	output logic              fd_wr,
	output logic              covox_wr,
	output logic              sd_cfg_wr,
	output logic              sd_dat_wr,
	output logic              sd_dat_rd,
	output logic              xstat_rd
);

	logic fd_hit;
	logic fb_hit;
	logic xt_hit;

	assign fd_hit = (a.f.port == PORT_FD);
	assign fb_hit = (a.f.port == PORT_COVOX);
	assign xt_hit = (a.f.port == PORT_XT);

	// ports with read data, joystick and sd vanish while dos rom is paged in
	always_comb
	begin
		port_sel = PSEL_NONE;
		case (a.f.port)
			PORT_FE:
				port_sel = PSEL_FE;
			PORT_XT:
				port_sel = PSEL_XT;
			PORT_KMOUSE:
				port_sel = PSEL_KMOUSE;
			PORT_KJOY:
				if (!dos)
					port_sel = PSEL_KJOY;
			PORT_SDCFG:
				if (!dos)
					port_sel = PSEL_SDCFG;
			PORT_SDDAT:
				if (!dos)
					port_sel = PSEL_SDDAT;
			default:
				port_sel = PSEL_NONE;
		endcase
	end

	// #FD and #FB are write-only but still claimed on the bus
	assign porthit = (port_sel != PSEL_NONE) || fd_hit || fb_hit;

	assign external_port = fd_hit && a.raw[15];	// AY lives outside
	assign dataout       = porthit && iord && !external_port;

	assign xt_wr     = xt_hit && iowr_s;
	assign fe_wr     = (port_sel == PSEL_FE) && iowr_s;
	assign fd_wr     = fd_hit && !a.raw[15] && iowr_s;	// #7FFD, lock applied later
	assign covox_wr  = fb_hit && iowr_s;
	assign sd_cfg_wr = (port_sel == PSEL_SDCFG) && iowr_s;
	assign sd_dat_wr = (port_sel == PSEL_SDDAT) && iowr_s;
	assign sd_dat_rd = (port_sel == PSEL_SDDAT) && iord_s;

	assign xstat_rd = xt_hit && (a.f.xreg == XR_XSTAT) && iord_s;

endmodule

// ==== common/zports_pkg.sv ====
// I/O port block shared constants: port numbers, register indices, reset values, address view
package zports_pkg;

	// low address byte of each decoded port
	localparam logic [7:0] PORT_FE     = 8'hFE;	// keyboard, tape, border, beeper
	localparam logic [7:0] PORT_FD     = 8'hFD;	// #7FFD paging, AY with a15 set
	localparam logic [7:0] PORT_XT     = 8'hAF;	// extended registers #nnAF
	localparam logic [7:0] PORT_COVOX  = 8'hFB;
	localparam logic [7:0] PORT_KJOY   = 8'h1F;	// kempston joystick
	localparam logic [7:0] PORT_KMOUSE = 8'hDF;	// kempston mouse
	localparam logic [7:0] PORT_SDCFG  = 8'h77;	// sd card config
	localparam logic [7:0] PORT_SDDAT  = 8'h57;	// sd card data

	// extended register indices, carried in the high address byte
	localparam logic [7:0] XR_VCONF   = 8'h00;
	localparam logic [7:0] XR_VPAGE   = 8'h01;
	localparam logic [7:0] XR_TSCONF  = 8'h06;
	localparam logic [7:0] XR_PALSEL  = 8'h07;
	localparam logic [7:0] XR_XBORDER = 8'h0F;
	localparam logic [7:0] XR_RAMPAGE = 8'h10;	// base of #10..#13
	localparam logic [7:0] XR_FMADDR  = 8'h15;
	localparam logic [7:0] XR_SYSCONF = 8'h20;
	localparam logic [7:0] XR_MEMCONF = 8'h21;
	localparam logic [7:0] XR_IM2VECT = 8'h25;

	// read side index, shares its code with vconf
	localparam logic [7:0] XR_XSTAT   = 8'h00;

	// register contents after reset
	localparam logic [7:0] SYSCONF_RST  = 8'h01;	// turbo 7 MHz
	localparam logic [7:0] MEMCONF_RST  = 8'h04;	// rom map off
	localparam logic [7:0] IM2VECT_RST  = 8'hFF;
	localparam logic [7:0] RAMPAGE_RST0 = 8'h00;
	localparam logic [7:0] RAMPAGE_RST1 = 8'h05;
	localparam logic [7:0] RAMPAGE_RST2 = 8'h02;
	localparam logic [7:0] RAMPAGE_RST3 = 8'h00;

	// port select codes from the decoder to the read mux
	localparam int PSEL_W = 4;

	localparam logic [PSEL_W-1:0] PSEL_NONE   = 4'd0;	// no read data, bus sees #FF
	localparam logic [PSEL_W-1:0] PSEL_FE     = 4'd1;
	localparam logic [PSEL_W-1:0] PSEL_XT     = 4'd2;
	localparam logic [PSEL_W-1:0] PSEL_KJOY   = 4'd3;
	localparam logic [PSEL_W-1:0] PSEL_KMOUSE = 4'd4;
	localparam logic [PSEL_W-1:0] PSEL_SDCFG  = 4'd5;
	localparam logic [PSEL_W-1:0] PSEL_SDDAT  = 4'd6;

	// z80 i/o address, either as a plain word or as index over port byte
	typedef union packed
	{
		logic [15:0] raw;
		struct packed
		{
			logic [7:0] xreg;	// b register on OUT (C),r
			logic [7:0] port;
		} f;
	} zaddr_u;

endpackage
